// File: source/video_pkg.sv
// Video generator shared definitions
package video_pkg;

    // CPU write port
    localparam int addr_w = 10;       // Word address
    localparam int data_w = 16;

    // Pixel paths
    localparam int color_w   = 4;     // Layer colour code
    localparam int pal_idx_w = 5;     // Layer bit plus colour code
    localparam int rgb_w     = 5;     // One RGB555 channel

    // Raster counter widths
    localparam int hdump_w = 7;
    localparam int vdump_w = 6;

    // Memory sizes in words
    localparam int char_words = 32;   // 8x4 tile map
    localparam int pal_words  = 32;   // Char colours low half, objects high half

    // Object engine, one pass over the table per line
    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_test,
        st_draw,
        st_next
    } obj_state_t;

endpackage

// File: source/raster_timing.sv
// Raster timing generator
`timescale 1ns/10ps

module raster_timing #(
    parameter int h_active = 64,
    parameter int h_total  = 80,
    parameter int v_active = 32,
    parameter int v_total  = 40
) (
    input  logic                          clk,
    input  logic                          rst,
    output logic [video_pkg::hdump_w-1:0] hdump,
    output logic [video_pkg::vdump_w-1:0] vdump,
    output logic                          line_start,
    output logic                          hs,
    output logic                          vs,
    output logic                          pre_hbl,
    output logic                          pre_vbl
);

    localparam int hw = video_pkg::hdump_w;
    localparam int vw = video_pkg::vdump_w;

    localparam logic [hw-1:0] h_last   = hw'(h_total - 1);
    localparam logic [vw-1:0] v_last   = vw'(v_total - 1);
    localparam logic [hw-1:0] h_vis    = hw'(h_active);
    localparam logic [vw-1:0] v_vis    = vw'(v_active);
    localparam logic [hw-1:0] hs_start = hw'(h_active + 4);   // Sync sits in the blanking
    localparam logic [hw-1:0] hs_end   = hw'(h_active + 12);
    localparam logic [vw-1:0] vs_start = vw'(v_active + 2);
    localparam logic [vw-1:0] vs_end   = vw'(v_active + 4);

    logic [hw-1:0] h_next;
    logic [vw-1:0] v_next;

    // Levels are decoded from the next count so they line up with the counters
    always_comb begin
        h_next = hdump + 1'b1;
        v_next = vdump;
        if (hdump == h_last) begin
            h_next = '0;
            v_next = (vdump == v_last) ? '0 : vdump + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdump   <= '0;
            vdump   <= '0;
            hs      <= 1'b0;
            vs      <= 1'b0;
            pre_hbl <= 1'b1;          // Count 0 is visible
            pre_vbl <= 1'b1;
        end else begin
            hdump   <= h_next;
            vdump   <= v_next;
            hs      <= h_next >= hs_start && h_next < hs_end;
            vs      <= v_next >= vs_start && v_next < vs_end;
            pre_hbl <= h_next < h_vis;
            pre_vbl <= v_next < v_vis;
        end
    end

    assign line_start = hdump == '0;  // Kicks off the object scan

    a_count_range: assert property (@(posedge clk) disable iff (rst)
        hdump <= h_last && vdump <= v_last);

endmodule

// File: source/obj_line_fsm.sv
// Object line scan engine
`timescale 1ns/10ps

module obj_line_fsm #(
    parameter int h_active  = 64,
    parameter int v_total   = 40,
    parameter int obj_count = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           line_start,
    input  logic [video_pkg::vdump_w-1:0]  vdump,
    output logic [$clog2(2*obj_count)-1:0] obj_rd_idx,
    input  logic [video_pkg::data_w-1:0]   obj_rd_word,
    output logic                           buf_we,
    output logic [$clog2(h_active)-1:0]    buf_x,
    output logic [video_pkg::color_w-1:0]  buf_color
);

    localparam int n_w = $clog2(obj_count);
    localparam int vw  = video_pkg::vdump_w;

    localparam logic [n_w-1:0] last_obj  = n_w'(obj_count - 1);
    localparam logic [vw-1:0]  last_line = vw'(v_total - 1);
    localparam logic [8:0]     x_lim     = 9'(h_active);

    video_pkg::obj_state_t state;

    logic [n_w-1:0]                 obj_n;
    logic [vw-1:0]                  line;       // Line being prepared
    logic [7:0]                     x_r;
    logic [7:0]                     y_r;
    logic [video_pkg::color_w-1:0]  color_r;
    logic [2:0]                     px;
    logic [8:0]                     xpos;
    logic [7:0]                     dy;
    logic                           hit;
    logic                           obj_done;

    // Word 2n is addressed the cycle before st_read, word 2n+1 during it
    assign obj_rd_idx = {obj_n, state == video_pkg::st_read};

    assign xpos = {1'b0, x_r} + {6'd0, px};     // No wrap past the right edge
    assign dy   = {2'b00, line} - y_r;          // Row inside the object
    assign hit  = obj_rd_word[video_pkg::color_w-1:0] != '0 && dy < 8'd8;

    assign obj_done = (state == video_pkg::st_test && !hit) ||
                      (state == video_pkg::st_draw && px == 3'd7);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= video_pkg::st_idle;
            obj_n  <= '0;
            buf_we <= 1'b0;
        end else begin
            buf_we <= state == video_pkg::st_draw && xpos < x_lim;
            case (state)
                video_pkg::st_idle: begin
                    if (line_start)
                        state <= video_pkg::st_read;
                end
                video_pkg::st_read: state <= video_pkg::st_test;
                video_pkg::st_test: begin
                    if (hit)
                        state <= video_pkg::st_draw;
                end
                video_pkg::st_next: state <= video_pkg::st_read;
                default: ;
            endcase
            if (obj_done) begin
                if (obj_n == last_obj) begin
                    state <= video_pkg::st_idle;
                    obj_n <= '0;
                end else begin
                    state <= video_pkg::st_next;
                    obj_n <= obj_n + 1'b1;
                end
            end
        end
    end

    // Entry fields and draw position
    always_ff @(posedge clk) begin
        if (state == video_pkg::st_idle && line_start)
            line <= (vdump == last_line) ? '0 : vdump + 1'b1;
        if (state == video_pkg::st_read) begin
            x_r <= obj_rd_word[7:0];
            y_r <= obj_rd_word[15:8];
        end
        if (state == video_pkg::st_test) begin
            color_r <= obj_rd_word[video_pkg::color_w-1:0];
            px      <= '0;
        end else if (state == video_pkg::st_draw) begin
            px <= px + 1'b1;
        end
        buf_x     <= xpos[$clog2(h_active)-1:0];
        buf_color <= color_r;
    end

    // The scan must end before the next line starts
    a_scan_done: assert property (@(posedge clk) disable iff (rst)
        line_start |-> state == video_pkg::st_idle);

endmodule

// File: source/obj_line_buffer.sv
// Object table and line buffers
`timescale 1ns/10ps

module obj_line_buffer #(
    parameter int h_active  = 64,
    parameter int obj_count = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cpu_we,
    input  logic                           obj_cs,
    input  logic [video_pkg::addr_w-1:0]   cpu_addr,
    input  logic [video_pkg::data_w-1:0]   cpu_din,
    input  logic                           line_start,
    input  logic [video_pkg::hdump_w-1:0]  hdump,
    input  logic [$clog2(2*obj_count)-1:0] obj_rd_idx,
    output logic [video_pkg::data_w-1:0]   obj_rd_word,
    input  logic                           buf_we,
    input  logic [$clog2(h_active)-1:0]    buf_x,
    input  logic [video_pkg::color_w-1:0]  buf_color,
    output logic [video_pkg::color_w-1:0]  obj_pxl
);

    localparam int idx_w = $clog2(2*obj_count);
    localparam int x_w   = $clog2(h_active);

    localparam logic [video_pkg::hdump_w-1:0] h_vis = video_pkg::hdump_w'(h_active);

    logic [video_pkg::data_w-1:0]  obj_mem  [0:2*obj_count-1];
    logic [video_pkg::color_w-1:0] line_mem [0:2*h_active-1];  // Bank select in the MSB

    logic           sel;        // Bank on display
    logic           rd_bank;
    logic           rd_en;
    logic [x_w-1:0] rd_x;

    // Even words hold y:x, odd words the colour
    always_ff @(posedge clk) begin
        if (cpu_we && obj_cs)
            obj_mem[cpu_addr[idx_w-1:0]] <= cpu_din;
        obj_rd_word <= obj_mem[obj_rd_idx];
    end

    always_ff @(posedge clk) begin
        if (rst)
            sel <= 1'b0;
        else if (line_start)
            sel <= ~sel;
    end

    // The swap edge already reads the new front bank
    assign rd_bank = line_start ? ~sel : sel;
    assign rd_en   = hdump < h_vis;
    assign rd_x    = hdump[x_w-1:0];

    always_ff @(posedge clk) begin
        obj_pxl <= rd_en ? line_mem[{rd_bank, rd_x}] : '0;
        if (rd_en)
            line_mem[{rd_bank, rd_x}] <= '0;        // Clear behind the beam
        if (buf_we)
            line_mem[{~sel, buf_x}] <= buf_color;   // Back bank for the next line
    end

    // Back bank writes never land on the swap edge
    a_no_swap_write: assert property (@(posedge clk) disable iff (rst)
        buf_we |-> !line_start);

endmodule

// File: source/char_layer.sv
// Character tile layer
`timescale 1ns/10ps

module char_layer #(
    parameter int h_active = 64,
    parameter int v_active = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cpu_we,
    input  logic                          char_cs,
    input  logic [video_pkg::addr_w-1:0]  cpu_addr,
    input  logic [video_pkg::data_w-1:0]  cpu_din,
    input  logic [video_pkg::hdump_w-1:0] hdump,
    input  logic [video_pkg::vdump_w-1:0] vdump,
    output logic [video_pkg::color_w-1:0] char_pxl
);

    localparam int map_w = $clog2(video_pkg::char_words);
    localparam int col_w = $clog2(h_active / 8);
    localparam int row_w = map_w - col_w;

    localparam logic [video_pkg::hdump_w-1:0] h_vis = video_pkg::hdump_w'(h_active);
    localparam logic [video_pkg::vdump_w-1:0] v_vis = video_pkg::vdump_w'(v_active);

    logic [video_pkg::data_w-1:0] char_mem [0:video_pkg::char_words-1];
    logic [map_w-1:0]             tile_idx;
    logic [video_pkg::data_w-1:0] tile;
    logic                         pat_bit;
    logic                         visible;

    always_ff @(posedge clk) begin
        if (cpu_we && char_cs)
            char_mem[cpu_addr[map_w-1:0]] <= cpu_din;
    end

    // Row-major tile from the coarse beam position
    assign tile_idx = {vdump[row_w+2:3], hdump[col_w+2:3]};
    assign tile     = char_mem[tile_idx];
    assign pat_bit  = tile[3'd7 - hdump[2:0]];     // MSB is the leftmost pixel
    assign visible  = hdump < h_vis && vdump < v_vis;

    always_ff @(posedge clk) begin
        if (rst)
            char_pxl <= '0;
        else if (visible && pat_bit)
            char_pxl <= tile[11:8];
        else
            char_pxl <= '0;           // Clear bit shows the backdrop
    end

endmodule

// File: source/color_mixer.sv
// Layer priority and palette
`timescale 1ns/10ps

module color_mixer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          video_en,
    input  logic                          cpu_we,
    input  logic                          pal_cs,
    input  logic [video_pkg::addr_w-1:0]  cpu_addr,
    input  logic [video_pkg::data_w-1:0]  cpu_din,
    input  logic [video_pkg::hdump_w-1:0] hdump,
    input  logic [video_pkg::vdump_w-1:0] vdump,
    input  logic                          pre_hbl,
    input  logic                          pre_vbl,
    input  logic [video_pkg::color_w-1:0] obj_pxl,
    input  logic [video_pkg::color_w-1:0] char_pxl,
    output logic [video_pkg::rgb_w-1:0]   red,
    output logic [video_pkg::rgb_w-1:0]   green,
    output logic [video_pkg::rgb_w-1:0]   blue,
    output logic                          lhbl,
    output logic                          lvbl,
    output logic [video_pkg::hdump_w-1:0] pxl_h,
    output logic [video_pkg::vdump_w-1:0] pxl_v
);

    localparam int pal_w = $clog2(video_pkg::pal_words);

    logic [14:0]                      pal_mem [0:video_pkg::pal_words-1];
    logic [video_pkg::pal_idx_w-1:0]  pal_idx;
    logic [14:0]                      pal_rgb;
    logic [video_pkg::hdump_w-1:0]    h_d1;
    logic [video_pkg::vdump_w-1:0]    v_d1;
    logic                             hbl_d1;
    logic                             vbl_d1;
    logic                             show;

    always_ff @(posedge clk) begin
        if (cpu_we && pal_cs)
            pal_mem[cpu_addr[pal_w-1:0]] <= cpu_din[14:0];
    end

    // Objects over characters over backdrop
    always_comb begin
        if (obj_pxl != '0)
            pal_idx = {1'b1, obj_pxl};
        else if (char_pxl != '0)
            pal_idx = {1'b0, char_pxl};
        else
            pal_idx = '0;
    end

    assign pal_rgb = pal_mem[pal_idx];    // Layer pixels already carry one register
    assign show    = video_en && hbl_d1 && vbl_d1;

    // First stage matches the layer output register
    always_ff @(posedge clk) begin
        h_d1 <= hdump;
        v_d1 <= vdump;
        if (rst) begin
            hbl_d1 <= 1'b0;
            vbl_d1 <= 1'b0;
        end else begin
            hbl_d1 <= pre_hbl;
            vbl_d1 <= pre_vbl;
        end
    end

    always_ff @(posedge clk) begin
        red   <= show ? pal_rgb[14:10] : '0;
        green <= show ? pal_rgb[9:5]   : '0;
        blue  <= show ? pal_rgb[4:0]   : '0;
        pxl_h <= h_d1;
        pxl_v <= v_d1;
        if (rst) begin
            lhbl <= 1'b0;
            lvbl <= 1'b0;
        end else begin
            lhbl <= hbl_d1;
            lvbl <= vbl_d1;
        end
    end

endmodule

// File: source/video_top.sv
// Tile and sprite video top level
`timescale 1ns/10ps

module video_top #(
    parameter int h_active  = 64,
    parameter int h_total   = 80,
    parameter int v_active  = 32,
    parameter int v_total   = 40,
    parameter int obj_count = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          video_en,
    input  logic                          cpu_we,
    input  logic                          char_cs,
    input  logic                          obj_cs,
    input  logic                          pal_cs,
    input  logic [video_pkg::addr_w-1:0]  cpu_addr,
    input  logic [video_pkg::data_w-1:0]  cpu_din,
    output logic                          hs,
    output logic                          vs,
    output logic                          lhbl,
    output logic                          lvbl,
    output logic [video_pkg::hdump_w-1:0] pxl_h,
    output logic [video_pkg::vdump_w-1:0] pxl_v,
    output logic [video_pkg::rgb_w-1:0]   red,
    output logic [video_pkg::rgb_w-1:0]   green,
    output logic [video_pkg::rgb_w-1:0]   blue
);

    logic [video_pkg::hdump_w-1:0]  hdump;
    logic [video_pkg::vdump_w-1:0]  vdump;
    logic                           line_start;
    logic                           pre_hbl;
    logic                           pre_vbl;
    logic [$clog2(2*obj_count)-1:0] obj_rd_idx;
    logic [video_pkg::data_w-1:0]   obj_rd_word;
    logic                           buf_we;
    logic [$clog2(h_active)-1:0]    buf_x;
    logic [video_pkg::color_w-1:0]  buf_color;
    logic [video_pkg::color_w-1:0]  obj_pxl;
    logic [video_pkg::color_w-1:0]  char_pxl;

    raster_timing #(
        .h_active(h_active), .h_total(h_total), .v_active(v_active), .v_total(v_total)
    ) raster_timing_inst (
        .clk(clk), .rst(rst), .hdump(hdump), .vdump(vdump), .line_start(line_start),
        .hs(hs), .vs(vs), .pre_hbl(pre_hbl), .pre_vbl(pre_vbl)
    );

    obj_line_fsm #(
        .h_active(h_active), .v_total(v_total), .obj_count(obj_count)
    ) obj_line_fsm_inst (
        .clk(clk), .rst(rst), .line_start(line_start), .vdump(vdump),
        .obj_rd_idx(obj_rd_idx), .obj_rd_word(obj_rd_word),
        .buf_we(buf_we), .buf_x(buf_x), .buf_color(buf_color)
    );

    obj_line_buffer #(
        .h_active(h_active), .obj_count(obj_count)
    ) obj_line_buffer_inst (
        .clk(clk), .rst(rst), .cpu_we(cpu_we), .obj_cs(obj_cs),
        .cpu_addr(cpu_addr), .cpu_din(cpu_din),
        .line_start(line_start), .hdump(hdump),
        .obj_rd_idx(obj_rd_idx), .obj_rd_word(obj_rd_word),
        .buf_we(buf_we), .buf_x(buf_x), .buf_color(buf_color), .obj_pxl(obj_pxl)
    );

    char_layer #(
        .h_active(h_active), .v_active(v_active)
    ) char_layer_inst (
        .clk(clk), .rst(rst), .cpu_we(cpu_we), .char_cs(char_cs),
        .cpu_addr(cpu_addr), .cpu_din(cpu_din),
        .hdump(hdump), .vdump(vdump), .char_pxl(char_pxl)
    );

    color_mixer color_mixer_inst (
        .clk(clk), .rst(rst), .video_en(video_en), .cpu_we(cpu_we), .pal_cs(pal_cs),
        .cpu_addr(cpu_addr), .cpu_din(cpu_din),
        .hdump(hdump), .vdump(vdump), .pre_hbl(pre_hbl), .pre_vbl(pre_vbl),
        .obj_pxl(obj_pxl), .char_pxl(char_pxl),
        .red(red), .green(green), .blue(blue),
        .lhbl(lhbl), .lvbl(lvbl), .pxl_h(pxl_h), .pxl_v(pxl_v)
    );

endmodule

// File: tests/video_tb.sv
// Video generator testbench
`timescale 1ns/10ps

module video_tb;

    localparam int clk_period = 20;
    localparam int h_active   = 64;
    localparam int h_total    = 80;
    localparam int v_active   = 32;
    localparam int v_total    = 40;
    localparam int n_fields   = 6;      // Values stored per data line

    logic                          clk;
    logic                          rst;
    logic                          video_en;
    logic                          cpu_we;
    logic                          char_cs;
    logic                          obj_cs;
    logic                          pal_cs;
    logic [video_pkg::addr_w-1:0]  cpu_addr;
    logic [video_pkg::data_w-1:0]  cpu_din;
    logic                          hs;
    logic                          vs;
    logic                          lhbl;
    logic                          lvbl;
    logic [video_pkg::hdump_w-1:0] pxl_h;
    logic [video_pkg::vdump_w-1:0] pxl_v;
    logic [video_pkg::rgb_w-1:0]   red;
    logic [video_pkg::rgb_w-1:0]   green;
    logic [video_pkg::rgb_w-1:0]   blue;

    byte kind_q[$];                     // W, C or E per data line
    int  field_q[$];
    int  n_writes;
    int  errors;
    int  checks;
    int  cur_test;
    int  test_errors;
    int  test_checks;
    int  tests_passed;
    int  tests_failed;
    bit  loaded;
    bit  in_frame;

    video_top #(
        .h_active(h_active), .h_total(h_total), .v_active(v_active), .v_total(v_total),
        .obj_count(4)
    ) video_top_inst (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic log_fail(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    // Sync follows the raster counter, two pixels ahead of pxl_h
    function automatic logic hs_expected(input int h);
        int hd;
        hd = (h + 2) % h_total;
        return hd >= 68 && hd <= 75;
    endfunction

    function automatic logic vs_expected(input int h, input int v);
        int vd;
        vd = (h + 2 >= h_total) ? (v + 1) % v_total : v;   // Counter already on the next line
        return vd >= 34 && vd <= 35;
    endfunction

    task automatic load_tests();
        int    fd;
        int    code;
        int    vals[n_fields];
        byte   kind;
        byte   sel;
        string text;
        fd = $fopen("tests/video_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/video_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            foreach (vals[k])
                vals[k] = 0;
            if (code == 1 && kind == "#") begin
                code = $fgets(text, fd);
            end else if (code == 1) begin
                case (kind)
                    "W": begin
                        code = $fscanf(fd, " %c %h %h", sel, vals[1], vals[2]);
                        vals[0] = sel;
                        n_writes++;
                    end
                    "C": code = $fscanf(fd, " %d %d %d %d %d %d",
                                        vals[0], vals[1], vals[2], vals[3], vals[4], vals[5]);
                    "E": code = $fscanf(fd, " %d", vals[0]);
                    default: begin
                        $display("Unknown line kind %c in the test data", kind);
                        errors++;
                    end
                endcase
                kind_q.push_back(kind);
                foreach (vals[k])
                    field_q.push_back(vals[k]);
            end
        end
        $fclose(fd);
    endtask

    task automatic write_mem(input int sel, input int addr, input int data);
        cpu_we   = 1'b1;
        char_cs  = sel == "c";
        obj_cs   = sel == "o";
        pal_cs   = sel == "p";
        cpu_addr = video_pkg::addr_w'(addr);
        cpu_din  = video_pkg::data_w'(data);
        next_cycle();
        cpu_we  = 1'b0;
        char_cs = 1'b0;
        obj_cs  = 1'b0;
        pal_cs  = 1'b0;
    endtask

    // Frame one may still show lines scanned before the writes
    task automatic wait_second_frame();
        while (pxl_v == 0)
            next_cycle();
        while (pxl_v != 0 || pxl_h != 0)
            next_cycle();
        in_frame = 1'b1;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %0d passed, %0d checks", cur_test, test_checks);
        end else begin
            tests_failed++;
            $display("Test %0d failed, %0d mismatches in %0d checks",
                     cur_test, test_errors, test_checks);
        end
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic check_pixel(input int test, input int h, input int v,
                               input int r, input int g, input int b);
        if (test != cur_test) begin
            if (cur_test != 0)
                finish_test();
            cur_test = test;
        end
        if (!in_frame)
            wait_second_frame();
        while (pxl_h != h || pxl_v != v)
            next_cycle();
        checks++;
        test_checks++;
        if (red != r || green != g || blue != b)
            log_fail($sformatf("test %0d pixel (%0d,%0d) rgb %0d/%0d/%0d, expected %0d/%0d/%0d",
                               test, h, v, red, green, blue, r, g, b));
        if (lhbl != (h < h_active) || lvbl != (v < v_active))
            log_fail($sformatf("test %0d pixel (%0d,%0d) lhbl/lvbl %b%b, expected %b%b",
                               test, h, v, lhbl, lvbl, h < h_active, v < v_active));
        if (hs != hs_expected(h) || vs != vs_expected(h, v))
            log_fail($sformatf("test %0d pixel (%0d,%0d) hs/vs %b%b, expected %b%b",
                               test, h, v, hs, vs, hs_expected(h), vs_expected(h, v)));
        next_cycle();
    endtask

    task automatic run_tests();
        int base;
        for (int i = 0; i < kind_q.size(); i++) begin
            base = i * n_fields;
            case (kind_q[i])
                "W": write_mem(field_q[base], field_q[base + 1], field_q[base + 2]);
                "E": video_en = field_q[base] != 0;
                "C": check_pixel(field_q[base], field_q[base + 1], field_q[base + 2],
                                 field_q[base + 3], field_q[base + 4], field_q[base + 5]);
                default: ;
            endcase
        end
        if (cur_test != 0)
            finish_test();
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        video_en = 1'b1;
        cpu_we   = 1'b0;
        char_cs  = 1'b0;
        obj_cs   = 1'b0;
        pal_cs   = 1'b0;
        cpu_addr = '0;
        cpu_din  = '0;
        load_tests();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        if (errors == 0)
            run_tests();
        $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_passed > 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // Three frames plus the write phase
    initial begin
        wait (loaded);
        #((3 * h_total * v_total + n_writes) * clk_period);
        $display("Timeout: the checks did not complete in time");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: files.f
source/video_pkg.sv
source/raster_timing.sv
source/obj_line_fsm.sv
source/obj_line_buffer.sv
source/char_layer.sv
source/color_mixer.sv
source/video_top.sv
tests/video_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0 -Wno-fatal
TOP       = video_tb
FILELIST  = files.f

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /TEST PASS/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: tests/video_tests.txt
# W sel(c/o/p) addr(hex) data(hex) | E video_en
# C test h v red green blue, all decimal, expected at pxl_h and pxl_v
W p 000 0864
W p 003 7c0a
W p 005 03e0
W p 016 294a
W p 017 50a1
W p 019 073e
W c 000 0000
W c 001 03a5
W c 00a 05ff
W c 018 0000
W o 000 0912
W o 001 0006
W o 002 0a14
W o 003 0000
W o 004 1436
W o 005 0007
W o 006 163c
W o 007 0009
C 1 3 2 2 3 4
C 1 5 6 2 3 4
C 2 8 6 31 0 10
C 2 9 6 2 3 4
C 2 12 7 2 3 4
C 2 13 7 31 0 10
C 3 20 8 0 31 0
C 3 17 9 0 31 0
C 3 18 9 10 10 10
C 3 21 11 10 10 10
C 4 58 24 20 5 1
C 4 61 24 1 25 30
C 4 63 24 1 25 30
C 4 1 25 2 3 4
C 5 66 25 0 0 0
C 5 70 26 0 0 0
C 5 20 35 0 0 0
E 0
C 6 8 2 0 0 0
C 6 20 10 0 0 0
